/* common/bus_pkg.sv */
package bus_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    // one mask bit per byte lane
    localparam int WEM_W = 4;

    // top address nibble picks the slave
    localparam int REGION_W = 4;
    localparam int OFFSET_W = ADDR_W - REGION_W;

    localparam logic [REGION_W-1:0] REGION_SRAM0 = 4'h0;
    // region 1 aliases the same sram
    localparam logic [REGION_W-1:0] REGION_SRAM1 = 4'h1;
    localparam logic [REGION_W-1:0] REGION_TIMER = 4'h2;
    localparam logic [REGION_W-1:0] REGION_GPIO = 4'h4;

    // one-hot owner vector, bit positions
    localparam int OWNER_W = 5;
    localparam int OWN_IDLE = 0;
    localparam int OWN_SRAM = 1;
    localparam int OWN_TIMER = 2;
    localparam int OWN_GPIO = 3;
    localparam int OWN_ERR = 4;

    // raw address word or region/offset split
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [REGION_W-1:0] region;
            logic [OFFSET_W-1:0] offset;
        } f;
    } bus_addr_u;

endpackage

/* common/periph_pkg.sv */
package periph_pkg;

    // sram size, word addressed
    localparam int SRAM_WORDS = 1024;
    localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);

    // edges from acceptance to data_ok
    localparam int SRAM_WAIT = 2;
    localparam int SRAM_CNT_W = $clog2(SRAM_WAIT + 1);
    // timer, gpio and the error sink
    localparam int REG_WAIT = 1;

    // timer register offsets
    localparam logic [7:0] TMR_CTRL = 8'h00;
    localparam logic [7:0] TMR_COUNT = 8'h04;
    localparam logic [7:0] TMR_CMP = 8'h08;

    // gpio register offsets
    localparam logic [7:0] GPIO_OUT = 8'h00;
    localparam logic [7:0] GPIO_IN = 8'h04;

    // pin count, one full data word
    localparam int GPIO_W = 32;

endpackage

/* common/sbus_if.sv */
interface sbus_if;
    import bus_pkg::*;

    // request side, from the router
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic req;
    logic we;
    logic [WEM_W-1:0] wem;

    // response side, from the slave
    logic [DATA_W-1:0] rdata;
    // combinational from req
    logic addr_ok;
    // one-cycle pulse per accepted request
    logic data_ok;

    modport master (
        output addr, wdata, req, we, wem,
        input  rdata, addr_ok, data_ok
    );

    modport slave (
        input  addr, wdata, req, we, wem,
        output rdata, addr_ok, data_ok
    );

endinterface

/* hw/bus_fabric/bus_ctrl.sv */
module bus_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic [bus_pkg::OWNER_W-1:0] sel_hit_i,
    input  logic acc_i,
    input  logic rsp_i,
    output logic pass_o,
    output logic [bus_pkg::OWNER_W-1:0] owner_o
);
    import bus_pkg::*;
    import periph_pkg::*;

    // one-hot, which slave owes the next response
    logic [OWNER_W-1:0] owner_q;
    logic [OWNER_W-1:0] owner_d;

    // new request may go out when nothing is owed
    // or the owed response is returning right now
    assign pass_o = owner_q[OWN_IDLE] | rsp_i;
    assign owner_o = owner_q;

    always_comb begin
        owner_d = owner_q;
        if (acc_i) begin
            // accepted request takes over ownership,
            // even in the cycle the old response leaves
            owner_d = sel_hit_i;
        end else if (rsp_i) begin
            // response done, nothing new accepted
            owner_d = '0;
            owner_d[OWN_IDLE] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner_q <= '0;
            owner_q[OWN_IDLE] <= 1'b1;
        end else begin
            owner_q <= owner_d;
        end
    end

    // unmapped requests park here as the err owner,
    // the router's sink answers and drops rsp back in

    // exactly one owner at all times
    a_owner_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot(owner_q)
    );

    // router must not accept while a response is still owed
    a_acc_needs_pass: assert property (
        @(posedge clk) disable iff (!rst_n)
        acc_i |-> pass_o
    );

    // error sink answers after the register latency
    a_err_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(owner_q[OWN_ERR]) |-> ##(REG_WAIT - 1) rsp_i
    );

endmodule

/* hw/bus_fabric/bus_router.sv */
module bus_router (
    input  logic clk,
    input  logic rst_n,
    input  logic m_req_i,
    input  logic m_we_i,
    input  logic [bus_pkg::WEM_W-1:0] m_wem_i,
    input  logic [bus_pkg::ADDR_W-1:0] m_addr_i,
    input  logic [bus_pkg::DATA_W-1:0] m_wdata_i,
    output logic [bus_pkg::DATA_W-1:0] m_rdata_o,
    output logic m_addr_ok_o,
    output logic m_data_ok_o,
    input  logic pass_i,
    input  logic [bus_pkg::OWNER_W-1:0] owner_i,
    output logic [bus_pkg::OWNER_W-1:0] sel_hit_o,
    output logic acc_o,
    output logic rsp_o,
    sbus_if.master sram_bus,
    sbus_if.master tmr_bus,
    sbus_if.master gpio_bus
);
    import bus_pkg::*;

    bus_addr_u in_addr;
    bus_addr_u fwd_addr;
    logic [OWNER_W-1:0] sel;
    logic [OWNER_W-1:0] slv_addr_ok;
    logic [OWNER_W-1:0] slv_data_ok;
    // error sink
    logic err_req;
    logic err_ack_q;

    always_comb begin
        in_addr.raw = m_addr_i;
        // slaves only see the offset
        fwd_addr = in_addr;
        fwd_addr.f.region = '0;
        sel = '0;
        case (in_addr.f.region)
            REGION_SRAM0, REGION_SRAM1: sel[OWN_SRAM] = 1'b1;
            REGION_TIMER: sel[OWN_TIMER] = 1'b1;
            REGION_GPIO: sel[OWN_GPIO] = 1'b1;
            default: sel[OWN_ERR] = 1'b1;
        endcase
    end

    // steer the request to the selected slave only
    assign sram_bus.req = m_req_i & pass_i & sel[OWN_SRAM];
    assign sram_bus.addr = sel[OWN_SRAM] ? fwd_addr.raw : '0;
    assign sram_bus.wdata = sel[OWN_SRAM] ? m_wdata_i : '0;
    assign sram_bus.we = sel[OWN_SRAM] & m_we_i;
    assign sram_bus.wem = sel[OWN_SRAM] ? m_wem_i : '0;

    assign tmr_bus.req = m_req_i & pass_i & sel[OWN_TIMER];
    assign tmr_bus.addr = sel[OWN_TIMER] ? fwd_addr.raw : '0;
    assign tmr_bus.wdata = sel[OWN_TIMER] ? m_wdata_i : '0;
    assign tmr_bus.we = sel[OWN_TIMER] & m_we_i;
    assign tmr_bus.wem = sel[OWN_TIMER] ? m_wem_i : '0;

    assign gpio_bus.req = m_req_i & pass_i & sel[OWN_GPIO];
    assign gpio_bus.addr = sel[OWN_GPIO] ? fwd_addr.raw : '0;
    assign gpio_bus.wdata = sel[OWN_GPIO] ? m_wdata_i : '0;
    assign gpio_bus.we = sel[OWN_GPIO] & m_we_i;
    assign gpio_bus.wem = sel[OWN_GPIO] ? m_wem_i : '0;

    // sink is always free once pass allows it
    assign err_req = m_req_i & pass_i & sel[OWN_ERR];

    always_comb begin
        slv_addr_ok = '0;
        slv_addr_ok[OWN_SRAM] = sram_bus.addr_ok;
        slv_addr_ok[OWN_TIMER] = tmr_bus.addr_ok;
        slv_addr_ok[OWN_GPIO] = gpio_bus.addr_ok;
        slv_addr_ok[OWN_ERR] = err_req;
        slv_data_ok = '0;
        slv_data_ok[OWN_SRAM] = sram_bus.data_ok;
        slv_data_ok[OWN_TIMER] = tmr_bus.data_ok;
        slv_data_ok[OWN_GPIO] = gpio_bus.data_ok;
        slv_data_ok[OWN_ERR] = err_ack_q;
    end

    // addr_ok by selection, response by owner
    assign m_addr_ok_o = |(sel & slv_addr_ok);
    assign acc_o = m_req_i & m_addr_ok_o;
    assign rsp_o = |(owner_i & slv_data_ok);
    assign m_data_ok_o = rsp_o;
    assign sel_hit_o = sel;

    always_comb begin
        m_rdata_o = '0;
        if (owner_i[OWN_SRAM]) begin
            m_rdata_o = sram_bus.rdata;
        end else if (owner_i[OWN_TIMER]) begin
            m_rdata_o = tmr_bus.rdata;
        end else if (owner_i[OWN_GPIO]) begin
            m_rdata_o = gpio_bus.rdata;
        end
        // idle and err read as zero
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            err_ack_q <= 1'b0;
        end else begin
            err_ack_q <= acc_o & sel[OWN_ERR];
        end
    end

    // never two slaves asked at once
    a_req_onehot0: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({sram_bus.req, tmr_bus.req, gpio_bus.req})
    );

endmodule

/* hw/sram_slave.sv */
module sram_slave (
    input logic clk,
    input logic rst_n,
    sbus_if.slave bus
);
    import bus_pkg::*;
    import periph_pkg::*;

    logic [DATA_W-1:0] mem [SRAM_WORDS];
    logic [DATA_W-1:0] rdata_q;
    logic [SRAM_IDX_W-1:0] idx;
    logic [SRAM_CNT_W-1:0] cnt_q;
    logic pend_q;
    logic acc;

    // word index from offset bits 11..2
    assign idx = bus.addr[SRAM_IDX_W+1:2];

    // ready when idle or handing back the pending response
    assign bus.data_ok = pend_q & (cnt_q == '0);
    assign bus.addr_ok = bus.req & (~pend_q | bus.data_ok);
    assign acc = bus.req & bus.addr_ok;
    assign bus.rdata = rdata_q;

    // wait counter, loaded at acceptance
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
            cnt_q <= '0;
        end else if (acc) begin
            pend_q <= 1'b1;
            cnt_q <= SRAM_CNT_W'(SRAM_WAIT - 1);
        end else if (bus.data_ok) begin
            pend_q <= 1'b0;
        end else if (pend_q) begin
            cnt_q <= cnt_q - SRAM_CNT_W'(1);
        end
    end

    // array access happens at acceptance
    always_ff @(posedge clk) begin
        if (acc && bus.we) begin
            for (int b = 0; b < WEM_W; b++) begin
                if (bus.wem[b]) begin
                    mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
        if (acc && !bus.we) begin
            rdata_q <= mem[idx];
        end
    end

    // each data_ok matches an acceptance SRAM_WAIT edges back
    a_data_ok_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        bus.data_ok |-> $past(acc, SRAM_WAIT)
    );

endmodule

/* hw/periph_timer.sv */
module periph_timer (
    input  logic clk,
    input  logic rst_n,
    sbus_if.slave bus,
    output logic timer_irq_o
);
    import bus_pkg::*;
    import periph_pkg::*;

    // response delay line, one bit per wait edge
    logic [REG_WAIT-1:0] ack_sr;
    logic acc;
    logic wr_ctrl;
    logic wr_cmp;
    logic hit;
    // ctrl bits
    logic en_q;
    logic ie_q;
    logic pend_q;
    logic [DATA_W-1:0] count_q;
    logic [DATA_W-1:0] cmp_q;
    logic [DATA_W-1:0] rdata_q;

    assign bus.data_ok = ack_sr[REG_WAIT-1];
    assign bus.addr_ok = bus.req & (~|ack_sr | bus.data_ok);
    assign acc = bus.req & bus.addr_ok;
    assign bus.rdata = rdata_q;

    // ctrl bits all live in the low byte
    assign wr_ctrl = acc & bus.we & bus.wem[0] & (bus.addr[7:0] == TMR_CTRL);
    assign wr_cmp = acc & bus.we & (bus.addr[7:0] == TMR_CMP);
    // compare match only counts while running
    assign hit = en_q & (count_q == cmp_q);
    assign timer_irq_o = pend_q & ie_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_sr <= '0;
            en_q <= 1'b0;
            ie_q <= 1'b0;
            pend_q <= 1'b0;
            count_q <= '0;
            cmp_q <= '0;
        end else begin
            ack_sr <= (ack_sr << 1) | REG_WAIT'(acc);
            if (wr_ctrl) begin
                en_q <= bus.wdata[0];
                ie_q <= bus.wdata[1];
            end
            // wrap on match, else count up
            if (hit) begin
                count_q <= '0;
            end else if (en_q) begin
                count_q <= count_q + DATA_W'(1);
            end
            // a new match beats a clear in the same cycle
            if (hit) begin
                pend_q <= 1'b1;
            end else if (wr_ctrl && bus.wdata[2]) begin
                pend_q <= 1'b0;
            end
            for (int b = 0; b < WEM_W; b++) begin
                if (wr_cmp && bus.wem[b]) begin
                    cmp_q[8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // read data captured at acceptance
    always_ff @(posedge clk) begin
        if (acc && !bus.we) begin
            case (bus.addr[7:0])
                TMR_CTRL: rdata_q <= {{(DATA_W - 3){1'b0}}, pend_q, ie_q, en_q};
                TMR_COUNT: rdata_q <= count_q;
                TMR_CMP: rdata_q <= cmp_q;
                default: rdata_q <= '0;
            endcase
        end
    end

endmodule

/* hw/periph_gpio.sv */
module periph_gpio (
    input  logic clk,
    input  logic rst_n,
    sbus_if.slave bus,
    input  logic [periph_pkg::GPIO_W-1:0] gpio_i,
    output logic [periph_pkg::GPIO_W-1:0] gpio_o
);
    import bus_pkg::*;
    import periph_pkg::*;

    logic [REG_WAIT-1:0] ack_sr;
    logic acc;
    logic wr_out;
    logic [GPIO_W-1:0] out_q;
    // two-flop synchronizer for the pins
    logic [GPIO_W-1:0] in_meta_q;
    logic [GPIO_W-1:0] in_sync_q;
    logic [DATA_W-1:0] rdata_q;

    assign bus.data_ok = ack_sr[REG_WAIT-1];
    assign bus.addr_ok = bus.req & (~|ack_sr | bus.data_ok);
    assign acc = bus.req & bus.addr_ok;
    assign bus.rdata = rdata_q;
    // IN is read-only, writes there are dropped
    assign wr_out = acc & bus.we & (bus.addr[7:0] == GPIO_OUT);
    assign gpio_o = out_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_sr <= '0;
            out_q <= '0;
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            ack_sr <= (ack_sr << 1) | REG_WAIT'(acc);
            in_meta_q <= gpio_i;
            in_sync_q <= in_meta_q;
            // byte lanes merge into the old value
            for (int b = 0; b < WEM_W; b++) begin
                if (wr_out && bus.wem[b]) begin
                    out_q[8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc && !bus.we) begin
            case (bus.addr[7:0])
                GPIO_OUT: rdata_q <= out_q;
                GPIO_IN: rdata_q <= in_sync_q;
                default: rdata_q <= '0;
            endcase
        end
    end

endmodule

/* hw/soc_bus_top.sv */
module soc_bus_top (
    input  logic clk,
    input  logic rst_n,
    // cpu-side master port
    input  logic m_req_i,
    input  logic m_we_i,
    input  logic [bus_pkg::WEM_W-1:0] m_wem_i,
    input  logic [bus_pkg::ADDR_W-1:0] m_addr_i,
    input  logic [bus_pkg::DATA_W-1:0] m_wdata_i,
    output logic [bus_pkg::DATA_W-1:0] m_rdata_o,
    output logic m_addr_ok_o,
    output logic m_data_ok_o,
    // pins
    input  logic [periph_pkg::GPIO_W-1:0] gpio_i,
    output logic [periph_pkg::GPIO_W-1:0] gpio_o,
    output logic timer_irq_o
);
    import bus_pkg::*;

    // ctrl <-> router handshake
    logic [OWNER_W-1:0] sel_hit;
    logic [OWNER_W-1:0] owner;
    logic acc;
    logic rsp;
    logic pass;

    // one bus per slave
    sbus_if sram_bus ();
    sbus_if tmr_bus ();
    sbus_if gpio_bus ();

    bus_ctrl i_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel_hit_i (sel_hit),
        .acc_i     (acc),
        .rsp_i     (rsp),
        .pass_o    (pass),
        .owner_o   (owner)
    );

    bus_router i_router (
        .clk         (clk),
        .rst_n       (rst_n),
        .m_req_i     (m_req_i),
        .m_we_i      (m_we_i),
        .m_wem_i     (m_wem_i),
        .m_addr_i    (m_addr_i),
        .m_wdata_i   (m_wdata_i),
        .m_rdata_o   (m_rdata_o),
        .m_addr_ok_o (m_addr_ok_o),
        .m_data_ok_o (m_data_ok_o),
        .pass_i      (pass),
        .owner_i     (owner),
        .sel_hit_o   (sel_hit),
        .acc_o       (acc),
        .rsp_o       (rsp),
        .sram_bus    (sram_bus.master),
        .tmr_bus     (tmr_bus.master),
        .gpio_bus    (gpio_bus.master)
    );

    sram_slave i_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (sram_bus.slave)
    );

    periph_timer i_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (tmr_bus.slave),
        .timer_irq_o (timer_irq_o)
    );

    periph_gpio i_gpio (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (gpio_bus.slave),
        .gpio_i (gpio_i),
        .gpio_o (gpio_o)
    );

endmodule

/* test/tb_soc_bus_top.sv */
module tb_soc_bus_top;
    timeunit 1ns;
    timeprecision 100ps;

    import bus_pkg::*;
    import periph_pkg::*;

    localparam logic [31:0] SEED = 32'h3f56;
    // extra rows added after the table is built
    localparam int POLL_MAX = 8;
    localparam int EXTRA_ROWS = POLL_MAX + 8;
    // 10 cycles to the compare match plus margin
    localparam int IRQ_BOUND = 10 + 3;
    localparam logic [2:0] CHK_RDATA = 3'b001;
    localparam logic [2:0] CHK_GPIO = 3'b010;
    localparam logic [2:0] CHK_IRQ = 3'b100;

    // one bus transfer and what it must return
    typedef struct packed {
        logic we;
        bus_addr_u addr;
        logic [DATA_W-1:0] wdata;
        logic [WEM_W-1:0] wem;
        logic [2:0] chk;
        logic [DATA_W-1:0] exp_rdata;
        logic [GPIO_W-1:0] exp_gpio;
        logic exp_irq;
        int lat;
    } row_t;

    logic clk;
    logic rst_n;
    logic m_req_i;
    logic m_we_i;
    logic [WEM_W-1:0] m_wem_i;
    logic [ADDR_W-1:0] m_addr_i;
    logic [DATA_W-1:0] m_wdata_i;
    logic [DATA_W-1:0] m_rdata_o;
    logic m_addr_ok_o;
    logic m_data_ok_o;
    logic [GPIO_W-1:0] gpio_i;
    logic [GPIO_W-1:0] gpio_o;
    logic timer_irq_o;

    row_t rows[$];
    // accepted requests waiting for data_ok
    int pend_idx[$];
    int pend_cyc[$];
    // reference models
    logic [DATA_W-1:0] sram_model [SRAM_WORDS];
    logic [GPIO_W-1:0] gpio_model;
    logic [DATA_W-1:0] rnd [10];
    logic [DATA_W-1:0] last_rdata;
    logic [GPIO_W-1:0] gpio_val;
    int cur_row;
    int cycle;
    int issued;
    int rsp_count;
    int mon_idx;
    int mon_cyc;
    int wd_ns;
    int first;
    int k;

    soc_bus_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .m_req_i     (m_req_i),
        .m_we_i      (m_we_i),
        .m_wem_i     (m_wem_i),
        .m_addr_i    (m_addr_i),
        .m_wdata_i   (m_wdata_i),
        .m_rdata_o   (m_rdata_o),
        .m_addr_ok_o (m_addr_ok_o),
        .m_data_ok_o (m_data_ok_o),
        .gpio_i      (gpio_i),
        .gpio_o      (gpio_o),
        .timer_irq_o (timer_irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED %s: got 0x%0h edges, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // byte lanes with a set mask bit take the new byte
    function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] data,
                                                      input logic [WEM_W-1:0] wem);
        logic [DATA_W-1:0] res;
        res = old;
        for (int b = 0; b < WEM_W; b++) begin
            if (wem[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(input logic [REGION_W-1:0] region,
                                                    input logic [OFFSET_W-1:0] offset);
        bus_addr_u a;
        a.f.region = region;
        a.f.offset = offset;
        return a.raw;
    endfunction

    // both sram regions wait SRAM_WAIT
    // everything else waits REG_WAIT
    function automatic int expected_latency(input bus_addr_u a);
        if (a.f.region == REGION_SRAM0 || a.f.region == REGION_SRAM1) begin
            return SRAM_WAIT;
        end
        return REG_WAIT;
    endfunction

    task automatic add_row(input logic we, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata, input logic [WEM_W-1:0] wem,
                           input logic [2:0] chk, input logic [DATA_W-1:0] exp_rdata,
                           input logic exp_irq);
        row_t r;
        r.we = we;
        r.addr.raw = addr;
        r.wdata = wdata;
        r.wem = wem;
        r.chk = chk;
        r.exp_rdata = exp_rdata;
        // gpio_o as it must look after this row
        r.exp_gpio = gpio_model;
        r.exp_irq = exp_irq;
        r.lat = expected_latency(r.addr);
        rows.push_back(r);
    endtask

    task automatic sram_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [WEM_W-1:0] wem);
        bus_addr_u a;
        a.raw = addr;
        // region bits ignored so region 1 lands on region 0 words
        sram_model[a.f.offset[11:2]] = merge_lanes(sram_model[a.f.offset[11:2]], data, wem);
        add_row(1'b1, addr, data, wem, 3'b000, '0, 1'b0);
    endtask

    task automatic sram_read(input logic [ADDR_W-1:0] addr);
        bus_addr_u a;
        a.raw = addr;
        add_row(1'b0, addr, '0, '0, CHK_RDATA, sram_model[a.f.offset[11:2]], 1'b0);
    endtask

    task automatic gpio_out_write(input logic [DATA_W-1:0] data, input logic [WEM_W-1:0] wem);
        gpio_model = merge_lanes(gpio_model, data, wem);
        add_row(1'b1, make_addr(REGION_GPIO, OFFSET_W'(GPIO_OUT)), data, wem, CHK_GPIO, '0,
                1'b0);
    endtask

    task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [2:0] chk, input logic exp_irq);
        add_row(1'b1, addr, data, '1, chk, '0, exp_irq);
    endtask

    task automatic reg_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
        add_row(1'b0, addr, '0, '0, CHK_RDATA, exp, 1'b0);
    endtask

    task automatic build_table();
        // sram through both regions
        // partial lanes merge into the model
        sram_write(make_addr(4'h1, 28'h000_0010), rnd[0], 4'hf);
        sram_read(make_addr(4'h0, 28'h000_0010));
        sram_write(make_addr(4'h0, 28'h000_0024), rnd[1], 4'hf);
        sram_write(make_addr(4'h1, 28'h000_0024), rnd[2], 4'b0101);
        sram_read(make_addr(4'h0, 28'h000_0024));
        sram_write(make_addr(4'h0, 28'h000_0ffc), rnd[3], 4'hf);
        sram_write(make_addr(4'h1, 28'h000_0ffc), rnd[4], 4'b1000);
        // empty mask leaves the word alone
        sram_write(make_addr(4'h0, 28'h000_0ffc), rnd[5], 4'b0000);
        sram_read(make_addr(4'h1, 28'h000_0ffc));
        sram_read(make_addr(4'h0, 28'h000_0010));
        // unmapped regions hit the error sink
        reg_read(make_addr(4'h3, 28'h000_0010), '0);
        reg_write(make_addr(4'h7, 28'h000_0000), rnd[6], 3'b000, 1'b0);
        reg_read(make_addr(4'h7, 28'hfff_fffc), '0);
        sram_read(make_addr(4'h0, 28'h000_0024));
        // gpio out register
        gpio_out_write(rnd[7], 4'hf);
        gpio_out_write(rnd[8], 4'b0110);
        reg_read(make_addr(REGION_GPIO, OFFSET_W'(GPIO_OUT)), gpio_model);
        // IN is read-only so gpio_o must not move
        add_row(1'b1, make_addr(REGION_GPIO, OFFSET_W'(GPIO_IN)), ~rnd[8], 4'hf, CHK_GPIO,
                '0, 1'b0);
        // timer compare setup with counting still off
        reg_write(make_addr(REGION_TIMER, OFFSET_W'(TMR_CMP)), 32'd9, 3'b000, 1'b0);
        reg_read(make_addr(REGION_TIMER, OFFSET_W'(TMR_CMP)), 32'd9);
        reg_read(make_addr(REGION_TIMER, OFFSET_W'(TMR_CTRL)), '0);
        // mixed slaves back to back
        sram_read(make_addr(4'h1, 28'h000_0010));
        reg_read(make_addr(REGION_GPIO, OFFSET_W'(GPIO_OUT)), gpio_model);
        reg_read(make_addr(4'hc, 28'h000_0100), '0);
        sram_read(make_addr(4'h0, 28'h000_0ffc));
        reg_read(make_addr(REGION_TIMER, OFFSET_W'(TMR_CMP)), 32'd9);
    endtask

    // hold the request until addr_ok
    task automatic issue_row(input int i);
        @(negedge clk);
        m_req_i = 1'b1;
        m_we_i = rows[i].we;
        m_addr_i = rows[i].addr.raw;
        m_wdata_i = rows[i].wdata;
        m_wem_i = rows[i].wem;
        cur_row = i;
        issued++;
        @(posedge clk);
        while (!m_addr_ok_o) begin
            @(posedge clk);
        end
    endtask

    task automatic finish_traffic();
        @(negedge clk);
        m_req_i = 1'b0;
        while (pend_idx.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic apply_rows(input int from, input int upto);
        for (int i = from; i <= upto; i++) begin
            issue_row(i);
        end
        finish_traffic();
    endtask

    // in-order response checker
    always @(posedge clk) begin
        if (rst_n) begin
            cycle = cycle + 1;
            if (m_data_ok_o) begin
                if (pend_idx.size() == 0) begin
                    $display("data_ok arrived with no request outstanding");
                    abort_run();
                end
                mon_idx = pend_idx.pop_front();
                mon_cyc = pend_cyc.pop_front();
                check_latency("m_data_ok_o latency", cycle - mon_cyc, rows[mon_idx].lat);
                if (rows[mon_idx].chk[0]) begin
                    check_data("m_rdata_o", m_rdata_o, rows[mon_idx].exp_rdata);
                end
                if (rows[mon_idx].chk[1]) begin
                    check_data("gpio_o", gpio_o, rows[mon_idx].exp_gpio);
                end
                if (rows[mon_idx].chk[2]) begin
                    check_flag("timer_irq_o", timer_irq_o, rows[mon_idx].exp_irq);
                end
                last_rdata = m_rdata_o;
                rsp_count++;
                // a waiting request goes in with the response
                if (m_req_i) begin
                    check_flag("m_addr_ok_o", m_addr_ok_o, 1'b1);
                end
            end
            if (m_req_i && m_addr_ok_o) begin
                pend_idx.push_back(cur_row);
                pend_cyc.push_back(cycle);
            end
        end
    end

    initial begin
        wait (wd_ns != 0);
        #(wd_ns);
        $display("timeout: bus traffic did not finish within %0d ns", wd_ns);
        abort_run();
    end

    initial begin
        rst_n = 1'b0;
        m_req_i = 1'b0;
        m_we_i = 1'b0;
        m_wem_i = '0;
        m_addr_i = '0;
        m_wdata_i = '0;
        gpio_i = '0;
        gpio_model = '0;
        cur_row = 0;
        cycle = 0;
        issued = 0;
        rsp_count = 0;
        wd_ns = 0;
        void'($urandom(SEED));
        for (int i = 0; i < 10; i++) begin
            rnd[i] = $urandom();
        end
        build_table();
        wd_ns = (rows.size() + EXTRA_ROWS) * (SRAM_WAIT + 2) * 4 * 4 + 2000;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        apply_rows(0, rows.size() - 1);

        // pin value through the synchronizer
        gpio_val = rnd[9];
        @(negedge clk);
        gpio_i = gpio_val;
        for (k = 0; k < POLL_MAX; k++) begin
            first = rows.size();
            add_row(1'b0, make_addr(REGION_GPIO, OFFSET_W'(GPIO_IN)), '0, '0, 3'b000, '0, 1'b0);
            apply_rows(first, first);
            if (last_rdata === gpio_val) begin
                break;
            end
        end
        check_data("gpio IN read", last_rdata, gpio_val);

        // count and interrupt on
        first = rows.size();
        reg_write(make_addr(REGION_TIMER, OFFSET_W'(TMR_CTRL)), 32'h3, CHK_IRQ, 1'b0);
        apply_rows(first, rows.size() - 1);
        for (k = 0; k < IRQ_BOUND && !timer_irq_o; k++) begin
            @(negedge clk);
        end
        check_flag("timer_irq_o", timer_irq_o, 1'b1);
        // stop counting first and then clear pending
        first = rows.size();
        reg_write(make_addr(REGION_TIMER, OFFSET_W'(TMR_CTRL)), 32'h2, CHK_IRQ, 1'b1);
        reg_write(make_addr(REGION_TIMER, OFFSET_W'(TMR_CTRL)), 32'h6, CHK_IRQ, 1'b0);
        reg_read(make_addr(REGION_TIMER, OFFSET_W'(TMR_CTRL)), 32'h2);
        reg_read(make_addr(REGION_TIMER, OFFSET_W'(TMR_CMP)), 32'd9);
        apply_rows(first, rows.size() - 1);
        check_flag("timer_irq_o", timer_irq_o, 1'b0);

        if (pend_idx.size() != 0 || rsp_count != issued) begin
            $display("request and response counts differ: %0d issued, %0d answered",
                     issued, rsp_count);
            abort_run();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

/* soc_bus_top.f */
common/bus_pkg.sv
common/periph_pkg.sv
common/sbus_if.sv
hw/bus_fabric/bus_ctrl.sv
hw/bus_fabric/bus_router.sv
hw/sram_slave.sv
hw/periph_timer.sv
hw/periph_gpio.sv
hw/soc_bus_top.sv
test/tb_soc_bus_top.sv

/* Makefile */
# Verilator build for the soc_bus_top testbench
# override any variable on the command line, e.g. make run BUILD_DIR=obj

VERILATOR ?= verilator
TOP       ?= tb_soc_bus_top
FILELIST  ?= soc_bus_top.f
BUILD_DIR ?= build
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

# exit status of the simulation is the test result
run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
